//--- intra_mode_select.f
+incdir+include
logic/intra_pkg.sv
logic/pixel_counter.sv
logic/intra_predictor.sv
logic/sse_accumulator.sv
logic/best_mode_keeper.sv
logic/intra_mode_fsm.sv
logic/intra_mode_select.sv
test/intra_mode_select_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the intra mode testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module intra_mode_select_tb -f intra_mode_select.f -o sim_intra

./obj_dir/sim_intra > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation passed"

//--- include/intra_tb_vectors.svh
// Stimulus table for the intra mode testbench; include inside the testbench after the package import
`ifndef INTRA_TB_VECTORS_SVH
`define INTRA_TB_VECTORS_SVH

// --------------------------------------------------
// Source pattern and expected mode codes
// --------------------------------------------------
localparam logic [2:0] PAT_TOP  = 3'd0;
localparam logic [2:0] PAT_LEFT = 3'd1;
localparam logic [2:0] PAT_DC   = 3'd2;
localparam logic [2:0] PAT_TM   = 3'd3;
// Source min(top[col], left[row]) is symmetric when top equals left
localparam logic [2:0] PAT_MIN  = 3'd4;
localparam logic [2:0] PAT_RAND = 3'd5;

localparam logic [2:0] EXP_DC  = 3'd0;
localparam logic [2:0] EXP_TM  = 3'd1;
localparam logic [2:0] EXP_VE  = 3'd2;
localparam logic [2:0] EXP_HE  = 3'd3;
localparam logic [2:0] EXP_ANY = 3'd4;

typedef struct packed {
    logic [31:0] top;
    logic [31:0] left;
    logic [7:0]  top_left;
    logic        top_avail;
    logic        left_avail;
    logic [15:0] lambda;
    logic [2:0]  pattern;
    logic [2:0]  exp_mode;
} vec_t;

localparam int NUM_VECS = 12;

// Each row holds top, left (pixel 3 in the high byte), top_left, top_avail, left_avail,
// lambda, source pattern and expected mode
localparam vec_t VECTORS [NUM_VECS] = '{
    '{32'hc8_78_3c_0a, 32'hdc_96_5a_1e, 8'd40,  1'b1, 1'b1, 16'd50,    PAT_TOP,  EXP_VE},
    '{32'hc8_78_3c_0a, 32'hdc_96_5a_1e, 8'd40,  1'b1, 1'b1, 16'd50,    PAT_LEFT, EXP_HE},
    '{32'h00_00_00_00, 32'hff_ff_ff_ff, 8'd0,   1'b0, 1'b0, 16'd100,   PAT_DC,   EXP_DC},
    '{32'h4e_38_22_0c, 32'he6_dc_d2_c8, 8'd100, 1'b1, 1'b0, 16'd30,    PAT_DC,   EXP_DC},
    '{32'h64_64_64_64, 32'h63_5f_5b_5a, 8'd100, 1'b0, 1'b1, 16'd30,    PAT_DC,   EXP_DC},
    '{32'h05_14_c8_fa, 32'h64_0a_1e_f0, 8'd60,  1'b1, 1'b1, 16'd20,    PAT_TM,   EXP_TM},
    '{32'hfa_1e_64_d2, 32'hb4_28_96_dc, 8'd200, 1'b1, 1'b1, 16'd5,     PAT_TM,   EXP_TM},
    // VE, HE and DC all reach SSE 2000 here
    '{32'h28_1e_14_0a, 32'h28_1e_14_0a, 8'd10,  1'b1, 1'b1, 16'd0,     PAT_MIN,  EXP_DC},
    '{32'h80_70_60_50, 32'h40_90_a0_b0, 8'd64,  1'b1, 1'b1, 16'd120,   PAT_RAND, EXP_ANY},
    '{32'h11_ee_22_dd, 32'h33_cc_44_bb, 8'd128, 1'b1, 1'b0, 16'd7,     PAT_RAND, EXP_ANY},
    '{32'hff_00_ff_00, 32'h7f_80_7f_80, 8'd255, 1'b0, 1'b1, 16'd65535, PAT_RAND, EXP_ANY},
    '{32'h9a_9a_9a_9a, 32'h65_65_65_65, 8'd0,   1'b0, 1'b0, 16'd0,     PAT_RAND, EXP_ANY}
};

`endif

//--- test/intra_mode_select_tb.sv
// Self-checking testbench; one request in flight, result compared with a behavioral model
`default_nettype none

module intra_mode_select_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import intra_pkg::*;

    `include "intra_tb_vectors.svh"

    localparam int CLK_PERIOD  = 8;
    localparam int WAIT_MAX    = 200;
    localparam int WATCHDOG_NS = (NUM_VECS * 100 + 10) * CLK_PERIOD;
    // Header cost per mode code
    localparam int HEADER_COST [4] = '{663, 919, 872, 919};

    logic          clk;
    logic          rst_n;
    logic          req;
    intra_block_t  blk;
    logic          ack;
    intra_result_t result;
    logic [15:0]   lfsr;
    int            errors;
    int            checks;

    intra_mode_select uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .blk    (blk),
        .ack    (ack),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

    task automatic check_equal(input string what, input logic [191:0] got,
                               input logic [191:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL at time %0t: %s, got %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // --------------------------------------------------
    // Stimulus and reference model
    // --------------------------------------------------
    // Taps 16, 14, 13, 11
    function automatic pixel_t random_byte();
        pixel_t v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int model_pred(input intra_block_t b, input int mode, input pix_idx_t idx);
        int ts;
        int ls;
        int tm;
        ts = 0;
        ls = 0;
        for (int i = 0; i < 4; i++) begin
            ts += int'(b.top[2'(i)]);
            ls += int'(b.left[2'(i)]);
        end
        tm = int'(b.top[idx[1:0]]) + int'(b.left[idx[3:2]]) - int'(b.top_left);
        case (mode)
            0: return (b.top_avail && b.left_avail) ? (ts + ls + 4) / 8 :
                      b.top_avail ? (ts + 2) / 4 : b.left_avail ? (ls + 2) / 4 : 128;
            1: return (tm < 0) ? 0 : ((tm > 255) ? 255 : tm);
            2: return int'(b.top[idx[1:0]]);
            default: return int'(b.left[idx[3:2]]);
        endcase
    endfunction

    task automatic build_block(input vec_t v, output intra_block_t b);
        pixel_t   px;
        pix_idx_t idx;
        b = '0;
        b.top        = v.top;
        b.left       = v.left;
        b.top_left   = v.top_left;
        b.top_avail  = v.top_avail;
        b.left_avail = v.left_avail;
        b.lambda     = v.lambda;
        for (int i = 0; i < 16; i++) begin
            idx = 4'(i);
            case (v.pattern)
                PAT_TOP:  px = b.top[idx[1:0]];
                PAT_LEFT: px = b.left[idx[3:2]];
                PAT_DC:   px = 8'(model_pred(b, 0, idx));
                PAT_TM:   px = 8'(model_pred(b, 1, idx));
                PAT_MIN:  px = (b.top[idx[1:0]] < b.left[idx[3:2]]) ? b.top[idx[1:0]]
                                                                     : b.left[idx[3:2]];
                default:  px = random_byte();
            endcase
            b.src[idx] = px;
        end
    endtask

    // Ascending code order with a strict compare keeps the lowest code on a tie
    task automatic model_result(input intra_block_t b, output intra_result_t want);
        longint sse;
        longint score;
        longint best_score;
        int     best_mode;
        int     d;
        best_score = 0;
        best_mode  = 0;
        for (int m = 0; m < 4; m++) begin
            sse = 0;
            for (int i = 0; i < 16; i++) begin
                d = int'(b.src[4'(i)]) - model_pred(b, m, 4'(i));
                sse += longint'(d * d);
            end
            score = longint'(HEADER_COST[m]) * longint'(b.lambda) + 256 * sse;
            if (m == 0 || score < best_score) begin
                best_score = score;
                best_mode  = m;
            end
        end
        want.mode  = intra_mode_e'(2'(best_mode));
        want.score = score_t'(best_score);
        for (int i = 0; i < 16; i++) begin
            want.pred[4'(i)] = 8'(model_pred(b, best_mode, 4'(i)));
        end
    endtask

    // --------------------------------------------------
    // Four-phase request
    // --------------------------------------------------
    task automatic run_request(input int n, input intra_block_t b, input intra_result_t want,
                               input logic [2:0] exp_mode);
        intra_result_t held;
        int            cycles;
        @(negedge clk);
        check_equal($sformatf("vec %0d ack before req", n), 192'(ack), 192'(0));
        blk = b;
        @(negedge clk);
        req = 1'b1;
        cycles = 0;
        while (!ack && cycles < WAIT_MAX) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            errors++;
            $display("Vector %0d got no ack within %0d cycles", n, WAIT_MAX);
        end else begin
            check_equal($sformatf("vec %0d mode", n), 192'(result.mode), 192'(want.mode));
            check_equal($sformatf("vec %0d score", n), 192'(result.score), 192'(want.score));
            check_equal($sformatf("vec %0d pred", n), 192'(result.pred), 192'(want.pred));
            if (exp_mode != EXP_ANY) begin
                check_equal($sformatf("vec %0d table mode", n), 192'(result.mode),
                            192'(exp_mode));
            end
            held = result;
            repeat (2 + n % 3) begin
                @(negedge clk);
                check_equal($sformatf("vec %0d ack held", n), 192'(ack), 192'(1));
                check_equal($sformatf("vec %0d result held", n), 192'(result), 192'(held));
            end
        end
        req = 1'b0;
        cycles = 0;
        while (ack && cycles < WAIT_MAX) begin
            @(negedge clk);
            cycles++;
        end
        if (ack) begin
            errors++;
            $display("Vector %0d kept ack high after req was dropped", n);
        end
    endtask

    initial begin
        intra_block_t  b;
        intra_result_t want;
        errors = 0;
        checks = 0;
        lfsr   = 16'd16500;
        rst_n  = 1'b0;
        req    = 1'b0;
        blk    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_equal("ack after reset", 192'(ack), 192'(0));
        check_equal("result after reset", 192'(result), 192'(0));
        for (int n = 0; n < NUM_VECS; n++) begin
            build_block(VECTORS[n], b);
            model_result(b, want);
            run_request(n, b, want, VECTORS[n].exp_mode);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/intra_mode_select.sv
// 4x4 luma intra mode decision top; blk must be stable when req rises, result valid while ack
`default_nettype none

module intra_mode_select (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req,
    input  intra_pkg::intra_block_t blk,
    output logic                   ack,
    output intra_pkg::intra_result_t result
);

    import intra_pkg::*;

    intra_block_t          blk_q;
    logic                  load;
    logic                  run;
    logic                  clear;
    logic                  score_en;
    logic                  take;
    logic                  first;
    logic                  last;
    intra_mode_e           mode;
    pix_idx_t              pix_idx;
    pixel_t                src_pix;
    pixel_t                pred_pix;
    sse_t                  sse;
    logic [BLK_BITS-1:0]   pred_blk;

    // Request capture
    always_ff @(posedge clk) begin
        if (load) begin
            blk_q <= blk;
        end
    end

    assign src_pix = blk_q.src[pix_idx];

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    intra_mode_fsm u_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .last     (last),
        .ack      (ack),
        .load     (load),
        .run      (run),
        .clear    (clear),
        .score_en (score_en),
        .take     (take),
        .first    (first),
        .mode     (mode)
    );

    pixel_counter u_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .clear   (clear),
        .pix_idx (pix_idx),
        .last    (last)
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    intra_predictor u_predictor (
        .blk      (blk_q),
        .mode     (mode),
        .pix_idx  (pix_idx),
        .pred_pix (pred_pix)
    );

    sse_accumulator u_accum (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .run      (run),
        .pix_idx  (pix_idx),
        .src_pix  (src_pix),
        .pred_pix (pred_pix),
        .sse      (sse),
        .pred_blk (pred_blk)
    );

    best_mode_keeper u_keeper (
        .clk        (clk),
        .rst_n      (rst_n),
        .blk_lambda (blk_q.lambda),
        .mode       (mode),
        .sse        (sse),
        .pred_blk   (pred_blk),
        .score_en   (score_en),
        .take       (take),
        .first      (first),
        .result     (result)
    );

endmodule

`default_nettype wire

//--- logic/intra_mode_fsm.sv
// Fixed 74-cycle sequence from capture to ack; four-phase req/ack, no abort once started
`default_nettype none

module intra_mode_fsm (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             req,
    input  wire logic             last,
    output logic                  ack,
    output logic                  load,
    output logic                  run,
    output logic                  clear,
    output logic                  score_en,
    output logic                  take,
    output logic                  first,
    output intra_pkg::intra_mode_e mode
);

    import intra_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN,
        ST_SCORE,
        ST_KEEP,
        ST_DONE,
        ST_RELEASE
    } state_e;

    state_e      state;
    state_e      state_nx;
    intra_mode_e mode_q;
    logic        first_q;
    logic        ack_q;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE:    if (req) state_nx = ST_LOAD;
            ST_LOAD:    state_nx = ST_RUN;
            ST_RUN:     if (last) state_nx = ST_SCORE;
            ST_SCORE:   state_nx = ST_KEEP;
            ST_KEEP:    state_nx = (mode_q == MODE_DC) ? ST_DONE : ST_RUN;
            // Hold result until requester drops req
            ST_DONE:    if (ack_q && !req) state_nx = ST_RELEASE;
            ST_RELEASE: state_nx = ST_IDLE;
            default:    state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mode_q  <= MODE_DC;
            first_q <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            state <= state_nx;
            ack_q <= (state == ST_DONE) && (state_nx == ST_DONE);
            if (state == ST_LOAD) begin
                mode_q  <= MODE_HE;
                first_q <= 1'b1;
            end else if (state == ST_KEEP) begin
                first_q <= 1'b0;
                if (mode_q != MODE_DC) begin
                    mode_q <= intra_mode_e'(mode_q - 2'd1);
                end
            end
        end
    end

    assign load     = (state == ST_IDLE) && req;
    assign run      = (state == ST_RUN);
    assign clear    = (state == ST_LOAD) || (state == ST_KEEP);
    assign score_en = (state == ST_SCORE);
    assign take     = (state == ST_KEEP);
    assign first    = first_q;
    assign mode     = mode_q;
    assign ack      = ack_q;

endmodule

`default_nettype wire

//--- logic/best_mode_keeper.sv
// Score = cost*lambda + 256*SSE in 32 bits; equal score replaces the kept mode
`default_nettype none

module best_mode_keeper (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [15:0]                   blk_lambda,
    input  intra_pkg::intra_mode_e             mode,
    input  intra_pkg::sse_t                    sse,
    input  wire logic [intra_pkg::BLK_BITS-1:0] pred_blk,
    input  wire logic                          score_en,
    input  wire logic                          take,
    input  wire logic                          first,
    output intra_pkg::intra_result_t           result
);

    import intra_pkg::*;

    score_t        rate_term;
    score_t        dist_term;
    score_t        score_q;
    intra_result_t best_q;

    // --------------------------------------------------
    // Score cycle
    // --------------------------------------------------
    assign rate_term = {16'd0, MODE_COST[mode]} * {16'd0, blk_lambda};
    assign dist_term = {3'd0, sse, 8'd0};

    always_ff @(posedge clk) begin
        if (score_en) begin
            score_q <= rate_term + dist_term;
        end
    end

    // --------------------------------------------------
    // Keep cycle
    // --------------------------------------------------
    // Passes run HE down to DC, so a tie leaves the lower code
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_q <= '0;
        end else if (take && (first || (score_q <= best_q.score))) begin
            best_q.mode  <= mode;
            best_q.score <= score_q;
            best_q.pred  <= pred_blk;
        end
    end

    assign result = best_q;

endmodule

`default_nettype wire

//--- logic/sse_accumulator.sv
// One pixel per run cycle; sum valid the cycle after last, buffer holds the last pass only
`default_nettype none

module sse_accumulator (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          clear,
    input  wire logic                          run,
    input  intra_pkg::pix_idx_t                pix_idx,
    input  intra_pkg::pixel_t                  src_pix,
    input  intra_pkg::pixel_t                  pred_pix,
    output intra_pkg::sse_t                    sse,
    output logic [intra_pkg::BLK_BITS-1:0]     pred_blk
);

    import intra_pkg::*;

    pixel_t                  abs_diff;
    logic [15:0]             sq_err;
    sse_t                    sse_q;
    pixel_t [BLK_PIXELS-1:0] pred_buf;

    assign abs_diff = (src_pix > pred_pix) ? (src_pix - pred_pix) : (pred_pix - src_pix);
    assign sq_err   = abs_diff * abs_diff;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sse_q <= '0;
        end else if (clear) begin
            sse_q <= '0;
        end else if (run) begin
            sse_q <= sse_q + {5'd0, sq_err};
        end
    end

    // Prediction slot per raster position
    always_ff @(posedge clk) begin
        if (run) begin
            pred_buf[pix_idx] <= pred_pix;
        end
    end

    assign sse      = sse_q;
    assign pred_blk = pred_buf;

endmodule

`default_nettype wire

//--- logic/intra_predictor.sv
// Combinational 4x4 predictor for DC, TM, VE, HE; edge pixels unused by a mode are ignored
`default_nettype none

module intra_predictor (
    input  intra_pkg::intra_block_t blk,
    input  intra_pkg::intra_mode_e  mode,
    input  intra_pkg::pix_idx_t     pix_idx,
    output intra_pkg::pixel_t       pred_pix
);

    import intra_pkg::*;

    logic [1:0]        row;
    logic [1:0]        col;
    logic [9:0]        top_sum;
    logic [9:0]        left_sum;
    logic [10:0]       both_sum;
    logic [9:0]        top_rnd;
    logic [9:0]        left_rnd;
    pixel_t            dc_pix;
    logic signed [9:0] tm_raw;
    pixel_t            tm_pix;

    assign row = pix_idx[3:2];
    assign col = pix_idx[1:0];

    // --------------------------------------------------
    // DC value
    // --------------------------------------------------
    assign top_sum  = {2'b00, blk.top[0]} + {2'b00, blk.top[1]}
                    + {2'b00, blk.top[2]} + {2'b00, blk.top[3]};
    assign left_sum = {2'b00, blk.left[0]} + {2'b00, blk.left[1]}
                    + {2'b00, blk.left[2]} + {2'b00, blk.left[3]};

    assign both_sum = {1'b0, top_sum} + {1'b0, left_sum} + 11'd4;
    assign top_rnd  = top_sum + 10'd2;
    assign left_rnd = left_sum + 10'd2;

    always_comb begin
        case ({blk.top_avail, blk.left_avail})
            2'b11:   dc_pix = both_sum[10:3];
            2'b10:   dc_pix = top_rnd[9:2];
            2'b01:   dc_pix = left_rnd[9:2];
            default: dc_pix = 8'd128;
        endcase
    end

    // --------------------------------------------------
    // TrueMotion with clip to 0..255
    // --------------------------------------------------
    assign tm_raw = $signed({2'b00, blk.top[col]}) + $signed({2'b00, blk.left[row]})
                  - $signed({2'b00, blk.top_left});

    always_comb begin
        if (tm_raw < 0) begin
            tm_pix = 8'd0;
        end else if (tm_raw > 10'sd255) begin
            tm_pix = 8'd255;
        end else begin
            tm_pix = tm_raw[7:0];
        end
    end

    always_comb begin
        case (mode)
            MODE_DC: pred_pix = dc_pix;
            MODE_TM: pred_pix = tm_pix;
            MODE_VE: pred_pix = blk.top[col];
            default: pred_pix = blk.left[row];
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pixel_counter.sv
// Raster walk over one 4x4 block; wraps to 0 after pixel 15, clear wins over run
`default_nettype none

module pixel_counter (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              run,
    input  wire logic              clear,
    output intra_pkg::pix_idx_t    pix_idx,
    output logic                   last
);

    import intra_pkg::*;

    pix_idx_t idx_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (clear) begin
            idx_q <= '0;
        end else if (run) begin
            // Natural 4-bit wrap
            idx_q <= idx_q + 4'd1;
        end
    end

    assign pix_idx = idx_q;
    assign last    = (idx_q == pix_idx_t'(BLK_PIXELS - 1));

endmodule

`default_nettype wire

//--- logic/intra_pkg.sv
// Shared types for 4x4 luma intra mode decision; 8-bit pixels only, no rate or spectral terms
`default_nettype none

package intra_pkg;

    // --------------------------------------------------
    // Block geometry
    // --------------------------------------------------
    localparam int BLK_DIM    = 4;
    localparam int BLK_PIXELS = BLK_DIM * BLK_DIM;
    localparam int NUM_MODES  = 4;
    localparam int BLK_BITS   = 8 * BLK_PIXELS;

    typedef logic [7:0] pixel_t;

    // Row in [3:2], column in [1:0]
    typedef logic [3:0] pix_idx_t;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } intra_mode_e;

    // 16 * 255^2 fits in 21 bits
    typedef logic [20:0] sse_t;
    typedef logic [31:0] score_t;

    // Header cost per mode, indexed by mode code
    localparam logic [15:0] MODE_COST [NUM_MODES] = '{
        16'd663,
        16'd919,
        16'd872,
        16'd919
    };

    // --------------------------------------------------
    // Request and result bundles
    // --------------------------------------------------
    typedef struct packed {
        pixel_t [BLK_PIXELS-1:0] src;
        pixel_t [BLK_DIM-1:0]    top;
        pixel_t [BLK_DIM-1:0]    left;
        pixel_t                  top_left;
        logic                    top_avail;
        logic                    left_avail;
        logic [15:0]             lambda;
    } intra_block_t;

    typedef struct packed {
        intra_mode_e             mode;
        score_t                  score;
        pixel_t [BLK_PIXELS-1:0] pred;
    } intra_result_t;

endpackage

`default_nettype wire
